// File: source/motor_settings.svh
`ifndef MOTOR_SETTINGS_SVH
`define MOTOR_SETTINGS_SVH

// step count, position and stroke width
`define STEP_W 16

// half-period in ticks, also table word width
`define SPEED_W 16

// ramp table address width
`define TABLE_AW 9

// microstep mode width
`define MS_W 3

// ticks of settling on direction reversal, 2 or more
`define REVERSE_DELAY 4

// 1 lets the zero sensor and stroke limit stop a move
`define USE_ZPD 1

`endif

// File: source/motor_pkg.sv
`default_nettype none

package motor_pkg;

	// axis state, bit 1 set whenever the axis is busy
	typedef enum logic [1:0] {
		ST_IDLE    = 2'b00,
		ST_SETTLE  = 2'b10,
		ST_RUNNING = 2'b11
	} seq_state_t;

	// which ramp table a write goes to
	typedef enum logic {
		TBL_ACCE = 1'b0,
		TBL_DEAC = 1'b1
	} table_sel_t;

endpackage

`default_nettype wire

// File: source/speed_lookup_if.sv
`default_nettype none

`include "motor_settings.svh"

interface speed_lookup_if;

	// request side, req is a one-cycle strobe
	logic               req;
	logic [`STEP_W-1:0]  step_cnt;
	logic [`STEP_W-1:0]  step_remain;
	logic [`SPEED_W-1:0] speed_max;

	// result, held until the next request completes
	logic [`SPEED_W-1:0] speed_cur;

	modport requester (
		output req, step_cnt, step_remain, speed_max,
		input  speed_cur
	);

	modport server (
		input  req, step_cnt, step_remain, speed_max,
		output speed_cur
	);

endinterface

`default_nettype wire

// File: source/speed_table.sv
`default_nettype none

`include "motor_settings.svh"

module speed_table #(
	parameter int AW = `TABLE_AW,
	parameter int DW = `SPEED_W
) (
	input  wire           clk,

	input  wire           i_wr_en,
	input  wire  [AW-1:0] i_wr_addr,
	input  wire  [DW-1:0] i_wr_data,

	input  wire           i_rd_en,
	input  wire  [AW-1:0] i_rd_addr,
	output logic [DW-1:0] o_rd_data
);

	logic [DW-1:0] mem [0:(1 << AW) - 1];
	logic [AW-1:0] rd_addr_q;
	logic          rd_en_q;

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// address stage, then data stage
	always_ff @(posedge clk) begin
		rd_en_q <= i_rd_en;
		if (i_rd_en)
			rd_addr_q <= i_rd_addr;
		if (rd_en_q)
			o_rd_data <= mem[rd_addr_q];
	end

endmodule

`default_nettype wire

// File: source/ramp_lookup.sv
`default_nettype none

`include "motor_settings.svh"

module ramp_lookup (
	input  wire                  clk,

	input  wire  [`TABLE_AW-1:0] i_acce_max,
	input  wire  [`TABLE_AW-1:0] i_deac_max,

	speed_lookup_if.server       lookup,

	output logic                 o_rd_en,
	output logic [`TABLE_AW-1:0] o_acce_addr,
	output logic [`TABLE_AW-1:0] o_deac_addr,
	input  wire  [`SPEED_W-1:0]  i_acce_data,
	input  wire  [`SPEED_W-1:0]  i_deac_data
);

	localparam int PAD_W = `STEP_W - `TABLE_AW;

	// req delayed by 1 to 5 cycles
	logic [5:1]          req_sr;
	logic                acce_ing;
	logic                deac_ing;
	logic [`SPEED_W-1:0] speed_var;

	always_ff @(posedge clk) begin
		req_sr <= {req_sr[4:1], lookup.req};
	end

	// still inside the table, or clamp to its last entry
	always_ff @(posedge clk) begin
		if (lookup.req) begin
			acce_ing <= (lookup.step_cnt < {{PAD_W{1'b0}}, i_acce_max});
			deac_ing <= (lookup.step_remain < {{PAD_W{1'b0}}, i_deac_max});
		end
	end

	always_ff @(posedge clk) begin
		if (req_sr[1]) begin
			o_acce_addr <= acce_ing ? lookup.step_cnt[`TABLE_AW-1:0] : i_acce_max;
			o_deac_addr <= deac_ing ? lookup.step_remain[`TABLE_AW-1:0] : i_deac_max;
		end
	end

	assign o_rd_en = req_sr[2];

	// table data lands two cycles after the read
	always_ff @(posedge clk) begin
		if (req_sr[4])
			speed_var <= (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
	end

	// longer period is slower, never beat the commanded speed
	always_ff @(posedge clk) begin
		if (req_sr[5])
			lookup.speed_cur <= (speed_var > lookup.speed_max) ? speed_var : lookup.speed_max;
	end

endmodule

`default_nettype wire

// File: source/step_sequencer.sv
`default_nettype none

`include "motor_settings.svh"

module step_sequencer (
	input  wire                 clk,
	input  wire                 resetn,

	input  wire                 i_tick,
	input  wire                 i_start,
	input  wire                 i_stop,
	input  wire  [`STEP_W-1:0]  i_step,
	input  wire  [`SPEED_W-1:0] i_speed,
	input  wire                 i_dir,
	input  wire  [`MS_W-1:0]    i_ms,
	input  wire                 i_end_stop,

	speed_lookup_if.requester   lookup,

	output logic                o_drive,
	output logic                o_dir,
	output logic [`MS_W-1:0]    o_ms,
	output logic                o_state
);

	localparam int DLY_W = (`REVERSE_DELAY > 2) ? $clog2(`REVERSE_DELAY) : 1;
	localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(`REVERSE_DELAY - 2);

	motor_pkg::seq_state_t state;

	logic                start_d1;
	logic                start_pend;
	logic                stop_d1;
	logic                stop_pend;
	logic                start_go;
	logic                is_idle;
	logic                cnt_zero;
	logic                finish;
	logic                req;
	logic                step_done;
	logic [DLY_W-1:0]    dly_cnt;
	logic [`SPEED_W-1:0] speed_cnt;
	logic [`SPEED_W-1:0] speed_max_q;
	logic [`STEP_W-1:0]  step_cnt;
	logic [`STEP_W-1:0]  step_remain;
	logic [`MS_W-1:0]    ms_q;

	assign is_idle  = (state == motor_pkg::ST_IDLE);
	assign cnt_zero = (speed_cnt == '0);
	assign start_go = i_tick && start_pend && is_idle;
	// last half period over with no toggle left
	assign finish   = step_done && cnt_zero;

	// rising edges, held until a tick takes them
	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_d1   <= 1'b0;
			start_pend <= 1'b0;
		end else begin
			start_d1 <= i_start;
			if (start_pend) begin
				if (i_tick)
					start_pend <= 1'b0;
			end else if (i_start && !start_d1 && is_idle) begin
				start_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			stop_d1   <= 1'b0;
			stop_pend <= 1'b0;
		end else begin
			stop_d1 <= i_stop;
			if (stop_pend) begin
				if (i_tick)
					stop_pend <= 1'b0;
			end else if (i_stop && !stop_d1 && !is_idle) begin
				stop_pend <= 1'b1;
			end
		end
	end

	// command latch
	always_ff @(posedge clk) begin
		if (start_go) begin
			speed_max_q <= i_speed;
			ms_q        <= i_ms;
		end
	end

	// stored direction, compared on the next start
	always_ff @(posedge clk) begin
		if (!resetn)
			o_dir <= 1'b0;
		else if (start_go)
			o_dir <= i_dir;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= motor_pkg::ST_IDLE;
		end else if (i_tick) begin
			case (state)
				motor_pkg::ST_IDLE: begin
					if (start_pend)
						state <= (o_dir == i_dir) ? motor_pkg::ST_RUNNING
						                          : motor_pkg::ST_SETTLE;
				end
				motor_pkg::ST_SETTLE: begin
					if (stop_pend)
						state <= motor_pkg::ST_IDLE;
					else if (dly_cnt == DLY_LAST)
						state <= motor_pkg::ST_RUNNING;
				end
				motor_pkg::ST_RUNNING: begin
					if (stop_pend || finish || i_end_stop)
						state <= motor_pkg::ST_IDLE;
				end
				default: state <= motor_pkg::ST_IDLE;
			endcase
		end
	end

	// settling ticks
	always_ff @(posedge clk) begin
		if (!resetn)
			dly_cnt <= '0;
		else if (i_tick) begin
			if (is_idle)
				dly_cnt <= '0;
			else if (state == motor_pkg::ST_SETTLE)
				dly_cnt <= dly_cnt + 1'b1;
		end
	end

	// one lookup per start and per completed pulse
	always_ff @(posedge clk) begin
		if (!resetn)
			req <= 1'b0;
		else if (req)
			req <= 1'b0;
		else if (i_tick) begin
			case (state)
				motor_pkg::ST_IDLE:    req <= start_pend;
				motor_pkg::ST_RUNNING: req <= cnt_zero && o_drive;
				default:               req <= 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt    <= '0;
			step_remain <= '0;
		end else if (i_tick) begin
			if (start_go) begin
				step_cnt    <= '0;
				step_remain <= i_step - 1'b1;
			end else if (state == motor_pkg::ST_RUNNING && cnt_zero && o_drive) begin
				step_cnt    <= step_cnt + 1'b1;
				step_remain <= step_remain - 1'b1;
			end
		end
	end

	// set on the falling edge of the last pulse
	always_ff @(posedge clk) begin
		if (!resetn)
			step_done <= 1'b0;
		else if (i_tick) begin
			if (state != motor_pkg::ST_RUNNING)
				step_done <= 1'b0;
			else if (o_drive && cnt_zero && step_remain == '0)
				step_done <= 1'b1;
		end
	end

	// half-period counter and step output
	always_ff @(posedge clk) begin
		if (!resetn) begin
			speed_cnt <= '0;
			o_drive   <= 1'b0;
		end else if (i_tick) begin
			case (state)
				motor_pkg::ST_RUNNING: begin
					speed_cnt <= cnt_zero ? lookup.speed_cur : speed_cnt - 1'b1;
					if (cnt_zero && !step_done)
						o_drive <= !o_drive;
				end
				motor_pkg::ST_SETTLE: begin
					o_drive <= 1'b0;
				end
				default: begin
					speed_cnt <= '0;
					o_drive   <= 1'b0;
				end
			endcase
		end
	end

	assign lookup.req         = req;
	assign lookup.step_cnt    = step_cnt;
	assign lookup.step_remain = step_remain;
	assign lookup.speed_max   = speed_max_q;

	assign o_ms    = ms_q;
	assign o_state = !is_idle;

endmodule

`default_nettype wire

// File: source/position_tracker.sv
`default_nettype none

`include "motor_settings.svh"

module position_tracker (
	input  wire                clk,
	input  wire                resetn,

	input  wire                i_drive,
	input  wire                i_dir,
	input  wire                i_zpd,
	input  wire  [`STEP_W-1:0] i_stroke,

	output logic               o_zpsign,
	output logic               o_tpsign,
	output logic               o_end_stop
);

	localparam bit USE_ZPD = (`USE_ZPD != 0);
	localparam logic [`STEP_W-1:0] HOME_POS = `STEP_W'(1);

	logic               drive_d1;
	logic               pulse_done;
	logic               at_end;
	logic               tp_flag;
	logic [`STEP_W-1:0] position;

	always_ff @(posedge clk) begin
		if (!resetn)
			drive_d1 <= 1'b0;
		else
			drive_d1 <= i_drive;
	end

	// falling edge of the step output
	assign pulse_done = drive_d1 && !i_drive;
	assign at_end     = (position == i_stroke);

	// forward counts up to the stroke, reverse down to home
	always_ff @(posedge clk) begin
		if (!resetn || i_zpd)
			position <= HOME_POS;
		else if (pulse_done) begin
			if (!i_dir) begin
				if (!at_end)
					position <= position + 1'b1;
			end else if (position > HOME_POS) begin
				position <= position - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			tp_flag <= 1'b0;
		else if (pulse_done)
			tp_flag <= at_end;
	end

	// only the limit in the direction of travel stops the move
	assign o_end_stop = USE_ZPD && ((tp_flag && !i_dir) || (i_zpd && i_dir));
	assign o_tpsign   = USE_ZPD && tp_flag;
	assign o_zpsign   = USE_ZPD && i_zpd;

endmodule

`default_nettype wire

// File: source/stepper_axis.sv
`default_nettype none

`include "motor_settings.svh"

module stepper_axis (
	input  wire                        clk,
	input  wire                        resetn,

	input  wire                        i_tick,
	input  wire                        i_start,
	input  wire                        i_stop,
	input  wire  [`STEP_W-1:0]         i_step,
	input  wire  [`SPEED_W-1:0]        i_speed,
	input  wire                        i_dir,
	input  wire  [`MS_W-1:0]           i_ms,

	input  wire  [`TABLE_AW-1:0]       i_acce_max,
	input  wire  [`TABLE_AW-1:0]       i_deac_max,

	// table load port
	input  wire                        i_tbl_wr,
	input  wire motor_pkg::table_sel_t i_tbl_sel,
	input  wire  [`TABLE_AW-1:0]       i_tbl_addr,
	input  wire  [`SPEED_W-1:0]        i_tbl_data,

	input  wire                        i_zpd,
	input  wire  [`STEP_W-1:0]         i_stroke,

	output wire                        o_drive,
	output wire                        o_dir,
	output wire  [`MS_W-1:0]           o_ms,
	output wire                        o_state,
	output wire  [`SPEED_W-1:0]        o_speed,
	output wire                        o_zpsign,
	output wire                        o_tpsign
);

	wire                 rd_en;
	wire [`TABLE_AW-1:0] acce_addr;
	wire [`TABLE_AW-1:0] deac_addr;
	wire [`SPEED_W-1:0]  acce_data;
	wire [`SPEED_W-1:0]  deac_data;
	wire                 acce_wr;
	wire                 deac_wr;
	wire                 end_stop;

	speed_lookup_if lookup_bus ();

	assign acce_wr = i_tbl_wr && (i_tbl_sel == motor_pkg::TBL_ACCE);
	assign deac_wr = i_tbl_wr && (i_tbl_sel == motor_pkg::TBL_DEAC);
	assign o_speed = lookup_bus.speed_cur;

	step_sequencer u_sequencer (
		.clk(clk), .resetn(resetn), .i_tick(i_tick),
		.i_start(i_start), .i_stop(i_stop), .i_step(i_step),
		.i_speed(i_speed), .i_dir(i_dir), .i_ms(i_ms),
		.i_end_stop(end_stop), .lookup(lookup_bus.requester),
		.o_drive(o_drive), .o_dir(o_dir), .o_ms(o_ms), .o_state(o_state)
	);

	ramp_lookup u_lookup (
		.clk(clk), .i_acce_max(i_acce_max), .i_deac_max(i_deac_max),
		.lookup(lookup_bus.server), .o_rd_en(rd_en),
		.o_acce_addr(acce_addr), .o_deac_addr(deac_addr),
		.i_acce_data(acce_data), .i_deac_data(deac_data)
	);

	speed_table u_acce_table (
		.clk(clk), .i_wr_en(acce_wr), .i_wr_addr(i_tbl_addr), .i_wr_data(i_tbl_data),
		.i_rd_en(rd_en), .i_rd_addr(acce_addr), .o_rd_data(acce_data)
	);

	speed_table u_deac_table (
		.clk(clk), .i_wr_en(deac_wr), .i_wr_addr(i_tbl_addr), .i_wr_data(i_tbl_data),
		.i_rd_en(rd_en), .i_rd_addr(deac_addr), .o_rd_data(deac_data)
	);

	position_tracker u_tracker (
		.clk(clk), .resetn(resetn), .i_drive(o_drive), .i_dir(o_dir),
		.i_zpd(i_zpd), .i_stroke(i_stroke),
		.o_zpsign(o_zpsign), .o_tpsign(o_tpsign), .o_end_stop(end_stop)
	);

endmodule

`default_nettype wire

// File: sim/tb_stepper_axis.sv
`default_nettype none

`include "motor_settings.svh"

module tb_stepper_axis;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TBL_N = 64;

	logic                  clk;
	logic                  resetn;
	logic                  i_tick;
	logic                  i_start;
	logic                  i_stop;
	logic [`STEP_W-1:0]    i_step;
	logic [`SPEED_W-1:0]   i_speed;
	logic                  i_dir;
	logic [`MS_W-1:0]      i_ms;
	logic [`TABLE_AW-1:0]  i_acce_max;
	logic [`TABLE_AW-1:0]  i_deac_max;
	logic                  i_tbl_wr;
	motor_pkg::table_sel_t i_tbl_sel;
	logic [`TABLE_AW-1:0]  i_tbl_addr;
	logic [`SPEED_W-1:0]   i_tbl_data;
	logic                  i_zpd;
	logic [`STEP_W-1:0]    i_stroke;
	logic                  o_drive;
	logic                  o_dir;
	logic [`MS_W-1:0]      o_ms;
	logic                  o_state;
	logic [`SPEED_W-1:0]   o_speed;
	logic                  o_zpsign;
	logic                  o_tpsign;

	integer seed = 22576;
	int     acce_tbl [0:TBL_N-1];
	int     deac_tbl [0:TBL_N-1];

	// command of the current move, and the position model
	int     cmd_step;
	int     cmd_speed;
	int     acce_max;
	int     deac_max;
	logic   cmd_dir = 1'b0;
	logic [`MS_W-1:0] cmd_ms = '0;
	int     pulse_cnt = 0;
	logic   drive_prev = 1'b0;
	logic   fell;
	logic   tp_next;
	int     model_pos = 1;
	logic   model_tp = 1'b0;
	int     stroke;
	int     tick_gap = 8;
	int     tick_num = 0;

	stepper_axis u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// tick strobe every 8 to 12 cycles
	always @(posedge clk) begin
		if (tick_gap == 0) begin
			i_tick   <= 1'b1;
			tick_num <= tick_num + 1;
			tick_gap <= 7 + (tick_num % 5);
		end else begin
			i_tick   <= 1'b0;
			tick_gap <= tick_gap - 1;
		end
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// slowest of the two ramp entries and the commanded period
	function automatic int speed_expect(input int k);
		int a_i;
		int d_i;
		int v;
		a_i = (k < acce_max) ? k : acce_max;
		d_i = (cmd_step - 1 - k < deac_max) ? cmd_step - 1 - k : deac_max;
		v = cmd_speed;
		if (acce_tbl[a_i] > v)
			v = acce_tbl[a_i];
		if (deac_tbl[d_i] > v)
			v = deac_tbl[d_i];
		return v;
	endfunction

	// pulse counting, profile checks and position model
	always @(posedge clk) begin
		if (resetn) begin
			if (o_drive && !drive_prev) begin
				if (pulse_cnt >= 1)
					check("o_speed", 32'(o_speed), 32'(speed_expect(pulse_cnt)));
				check("o_dir", 32'(o_dir), 32'(cmd_dir));
				check("o_ms", 32'(o_ms), 32'(cmd_ms));
				pulse_cnt = pulse_cnt + 1;
			end
			fell = drive_prev && !o_drive;
			tp_next = (model_pos == stroke);
			if (i_zpd)
				model_pos = 1;
			else if (fell && !cmd_dir && model_pos < stroke)
				model_pos = model_pos + 1;
			else if (fell && cmd_dir && model_pos > 1)
				model_pos = model_pos - 1;
			if (fell)
				model_tp = tp_next;
		end
		drive_prev = o_drive;
	end

	task automatic wait_state(input logic level);
		for (int n = 0; n < 20000; n++) begin
			@(posedge clk);
			if (o_state == level)
				return;
		end
		fail_now("timed out waiting for o_state to change");
	endtask

	task automatic wait_ticks(input int count);
		int seen;
		seen = 0;
		for (int n = 0; n < 100 * count; n++) begin
			@(posedge clk);
			if (i_tick)
				seen++;
			if (seen == count)
				return;
		end
		fail_now("timed out waiting for tick strobes");
	endtask

	task automatic wait_pulses(input int count);
		for (int n = 0; n < 20000; n++) begin
			@(posedge clk);
			if (pulse_cnt >= count || !o_state)
				return;
		end
		fail_now("timed out waiting for step pulses");
	endtask

	task automatic start_move(input int n, input logic dir);
		cmd_step  = n;
		cmd_dir   = dir;
		cmd_ms    = `MS_W'($random(seed));
		cmd_speed = 1 + {$random(seed)} % 5;
		acce_max  = {$random(seed)} % 32;
		deac_max  = {$random(seed)} % 32;
		pulse_cnt = 0;
		@(posedge clk);
		i_step     <= `STEP_W'(n);
		i_dir      <= dir;
		i_ms       <= cmd_ms;
		i_speed    <= `SPEED_W'(cmd_speed);
		i_acce_max <= `TABLE_AW'(acce_max);
		i_deac_max <= `TABLE_AW'(deac_max);
		i_start    <= 1'b1;
		@(posedge clk);
		i_start <= 1'b0;
		wait_state(1'b1);
	endtask

	task automatic end_checks();
		wait_ticks(2);
		check("o_drive", 32'(o_drive), 32'd0);
		check("o_tpsign", 32'(o_tpsign), 32'(model_tp));
		check("o_zpsign", 32'(o_zpsign), 32'(i_zpd));
	endtask

	task automatic normal_move(input int n, input logic dir);
		int exp_cnt;
		exp_cnt = n;
		if (!dir && stroke - model_pos + 1 < n)
			exp_cnt = stroke - model_pos + 1;
		start_move(n, dir);
		wait_state(1'b0);
		end_checks();
		check("pulse count", 32'(pulse_cnt), 32'(exp_cnt));
	endtask

	task automatic stop_move(input int n);
		int ticks;
		ticks = 0;
		start_move(n, 1'b1);
		wait_pulses(n / 2);
		@(posedge clk);
		i_stop <= 1'b1;
		@(posedge clk);
		i_stop <= 1'b0;
		for (int c = 0; c < 200 && o_state; c++) begin
			@(posedge clk);
			if (i_tick)
				ticks++;
		end
		if (o_state || ticks > 3)
			fail_now("stop strobe did not end the move within 3 ticks");
		end_checks();
		check("pulse count below step", 32'(pulse_cnt < n), 32'd1);
	endtask

	task automatic zero_sensor_move();
		start_move(20, 1'b1);
		wait_pulses(3);
		@(posedge clk);
		i_zpd <= 1'b1;
		wait_state(1'b0);
		check("o_zpsign", 32'(o_zpsign), 32'd1);
		end_checks();
		check("pulse count below step", 32'(pulse_cnt < 20), 32'd1);
		@(posedge clk);
		i_zpd <= 1'b0;
		@(posedge clk);
		@(posedge clk);
		check("o_zpsign", 32'(o_zpsign), 32'd0);
	endtask

	initial begin
		int n;
		logic dir;
		resetn     = 1'b0;
		i_tick     = 1'b0;
		i_start    = 1'b0;
		i_stop     = 1'b0;
		i_step     = '0;
		i_speed    = '0;
		i_dir      = 1'b0;
		i_ms       = '0;
		i_acce_max = '0;
		i_deac_max = '0;
		i_tbl_wr   = 1'b0;
		i_tbl_sel  = motor_pkg::TBL_ACCE;
		i_tbl_addr = '0;
		i_tbl_data = '0;
		i_zpd      = 1'b0;
		stroke     = 20 + {$random(seed)} % 10;
		i_stroke   = `STEP_W'(stroke);
		repeat (8) @(posedge clk);
		resetn <= 1'b1;

		// load both ramp tables
		for (int a = 0; a < 2 * TBL_N; a++) begin
			n = 1 + {$random(seed)} % 6;
			if (a < TBL_N)
				acce_tbl[a] = n;
			else
				deac_tbl[a - TBL_N] = n;
			@(posedge clk);
			i_tbl_wr   <= 1'b1;
			i_tbl_sel  <= (a < TBL_N) ? motor_pkg::TBL_ACCE : motor_pkg::TBL_DEAC;
			i_tbl_addr <= `TABLE_AW'(a % TBL_N);
			i_tbl_data <= `SPEED_W'(n);
		end
		@(posedge clk);
		i_tbl_wr <= 1'b0;

		// outputs still at their reset values
		check("o_drive", 32'(o_drive), 32'd0);
		check("o_state", 32'(o_state), 32'd0);
		check("o_tpsign", 32'(o_tpsign), 32'd0);

		for (int m = 0; m < 40; m++) begin
			n = 1 + {$random(seed)} % 16;
			dir = 1'($random(seed));
			// a forward start at the stroke end would stop at once
			if (model_tp)
				dir = 1'b1;
			if (m % 5 == 3)
				stop_move(6 + {$random(seed)} % 10);
			else
				normal_move(n, dir);
		end

		// drive into the stroke end
		for (int m = 0; m < 10 && !model_tp; m++)
			normal_move(16, 1'b0);
		check("o_tpsign at stroke end", 32'(o_tpsign), 32'd1);

		zero_sensor_move();
		normal_move(8, 1'b0);

		$display("All tests passed");
		$finish;
	end

	initial begin
		#50000000;
		fail_now("simulation ran past its time limit");
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/motor_pkg.sv
source/speed_lookup_if.sv
source/speed_table.sv
source/ramp_lookup.sv
source/step_sequencer.sv
source/position_tracker.sv
source/stepper_axis.sv
sim/tb_stepper_axis.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -f sources.f --top-module tb_stepper_axis -o sim_tb
	@out=$$(./obj_dir/sim_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
